/* ram2fifo.f */
hw/frame_pkg.sv
hw/lane_ram_pkg.sv
hw/frame_ctl_if.sv
hw/frame_sequencer.sv
hw/lane_addr_gen.sv
hw/frame_emitter.sv
hw/ram2fifo.sv
sim/lane_ram_model.sv
sim/tb_ram2fifo.sv

/* sim/tb_ram2fifo.sv */
`timescale 1ns/1ps

module tb_ram2fifo;

    typedef struct packed {
        lane_ram_pkg::lane_mask_t link;
        frame_pkg::data_len_t     data_len;
        frame_pkg::frame_idx_t    data_idx;
        lane_ram_pkg::lane_addr_t ram_rxa_init;
        logic [7:0]               full_cycles;   // fifo_full high before the frame
    } stim_row_t;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        fs;
    logic                        fd;
    lane_ram_pkg::lane_addr_t    ram_rxa_init;
    frame_pkg::data_len_t        data_len;
    lane_ram_pkg::lane_mask_t    link;
    frame_pkg::frame_idx_t       data_idx;
    lane_ram_pkg::ram_word_t     ram_rxd;
    lane_ram_pkg::ram_addr_bus_t ram_rxa;
    logic                        fifo_full;
    frame_pkg::frame_byte_t      fifo_txd;
    logic                        fifo_txen;

    stim_row_t              stim_table [$];
    frame_pkg::frame_byte_t exp_q [$];
    frame_pkg::frame_byte_t got_q [$];
    logic                   writes_allowed;
    int                     cycle_cnt = 0;
    int                     cycle_limit = 1000000;

    ram2fifo DUT (
        .clk          (clk),
        .rst          (rst),
        .fs           (fs),
        .fd           (fd),
        .ram_rxa_init (ram_rxa_init),
        .data_len     (data_len),
        .link         (link),
        .data_idx     (data_idx),
        .ram_rxd      (ram_rxd),
        .ram_rxa      (ram_rxa),
        .fifo_full    (fifo_full),
        .fifo_txd     (fifo_txd),
        .fifo_txen    (fifo_txen)
    );

    lane_ram_model u_ram (
        .clk     (clk),
        .ram_rxa (ram_rxa),
        .ram_rxd (ram_rxd)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input lane_ram_pkg::lane_mask_t link_v, input int len_v,
                           input int idx_v, input int init_v, input int full_v);
        stim_row_t row;
        row.link         = link_v;
        row.data_len     = frame_pkg::data_len_t'(len_v);
        row.data_idx     = frame_pkg::frame_idx_t'(idx_v);
        row.ram_rxa_init = lane_ram_pkg::lane_addr_t'(init_v);
        row.full_cycles  = 8'(full_v);
        stim_table.push_back(row);
    endtask

    task automatic load_stim_table();
        add_row(8'hFF,   4, 16'h0001, 12'h000, 0);  // All lanes, shortest length
        add_row(8'h01,   6, 16'h1234, 12'h010, 0);  // Single lane
        add_row(8'h55,   5, 16'h00A5, 12'h0FE, 4);  // Alternate lanes behind a full FIFO
        add_row(8'hAA,   7, 16'hBEEF, 12'h7F0, 0);
        add_row(8'h00,   9, 16'h8000, 12'h123, 5);  // Empty mask gives a bare frame
        add_row(8'h80,   6, 16'hFFFF, 12'hFFC, 0);  // Address wraps at 12 bits
        add_row(8'hFF, 200, 16'h0F0F, 12'hA5A, 2);  // Checksum wraps past 2^16
    endtask

    function automatic int compute_cycle_limit();
        int total;
        total = 200;
        foreach (stim_table[r]) begin
            total += 20 + 9 * (int'(stim_table[r].data_len) + 4) + int'(stim_table[r].full_cycles);
        end
        return total;
    endfunction

    // *****************************************************************
    // Expected frame from the frame rule and the RAM content formula
    // *****************************************************************

    task automatic build_expected(input stim_row_t row);
        int sum;
        int addr_i;
        exp_q.delete();
        exp_q.push_back(8'h55);
        exp_q.push_back(8'hAA);
        exp_q.push_back(8'h00);
        exp_q.push_back(row.link);
        exp_q.push_back(row.data_idx[15:8]);
        exp_q.push_back(row.data_idx[7:0]);
        sum = 0;
        for (int lane = 0; lane < lane_ram_pkg::NUM_LANES; lane++) begin
            if (row.link[lane]) begin
                for (int k = 0; k < int'(row.data_len); k++) begin
                    addr_i = (int'(row.ram_rxa_init) + k) % 4096;
                    exp_q.push_back(8'((lane * 37 + addr_i) % 256));
                    sum += (lane * 37 + addr_i) % 256;
                end
            end
        end
        sum = sum % 65536;
        exp_q.push_back(8'(sum / 256));
        exp_q.push_back(8'(sum % 256));
    endtask

    // Collects every FIFO write, which is only legal inside a frame before fd
    always @(negedge clk) begin
        if (!rst && fifo_txen === 1'b1) begin
            if (!writes_allowed || fd === 1'b1) begin
                $display("A byte was written to the FIFO outside a frame at %0t ns", $time);
                $display("test failed");
                $fatal(1, "stray FIFO write");
            end else begin
                got_q.push_back(fifo_txd);
            end
        end
    end

    always @(posedge clk) begin
        if (cycle_cnt >= cycle_limit) begin
            $display("The run took more than %0d cycles without finishing", cycle_limit);
            $display("test failed");
            $fatal(1, "timeout");
        end else begin
            cycle_cnt = cycle_cnt + 1;
        end
    end

    initial begin
        stim_row_t row;
        int        hold_cycles;
        void'($urandom(32'h47ec_94b3));
        load_stim_table();
        cycle_limit    = compute_cycle_limit();
        rst            = 1'b1;
        fs             = 1'b0;
        link           = '0;
        data_len       = frame_pkg::data_len_t'(4);
        data_idx       = '0;
        ram_rxa_init   = '0;
        fifo_full      = (stim_table[0].full_cycles != 0);
        writes_allowed = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        repeat (5) begin
            @(negedge clk);
            check_value("fd", 0, fd);
            check_value("fifo_txen", 0, fifo_txen);
        end

        for (int r = 0; r < stim_table.size(); r++) begin
            row = stim_table[r];
            build_expected(row);
            got_q.delete();
            @(posedge clk);
            #2;
            link         = row.link;
            data_len     = row.data_len;
            data_idx     = row.data_idx;
            ram_rxa_init = row.ram_rxa_init;
            fs           = 1'b1;
            if (row.full_cycles != 0) begin
                repeat (row.full_cycles) @(posedge clk);
                #2;
                fifo_full = 1'b0;
            end
            writes_allowed = 1'b1;
            while (fd !== 1'b1) @(negedge clk);
            #1;
            writes_allowed = 1'b0;
            check_value("frame length", exp_q.size(), got_q.size());
            for (int i = 0; i < exp_q.size(); i++) begin
                check_value("fifo_txd", exp_q[i], got_q[i]);
            end

            hold_cycles = $urandom_range(3, 1);  // fd must hold while fs stays high
            repeat (hold_cycles) begin
                @(negedge clk);
                check_value("fd", 1, fd);
            end
            @(posedge clk);
            #2;
            fs        = 1'b0;
            fifo_full = (r + 1 < stim_table.size()) && (stim_table[r + 1].full_cycles != 0);
            while (fd !== 1'b0) @(negedge clk);
        end

        $display("test passed");
        $finish;
    end

endmodule

/* sim/lane_ram_model.sv */
`timescale 1ns/1ps

module lane_ram_model (
    input  logic                        clk,
    input  lane_ram_pkg::ram_addr_bus_t ram_rxa,
    output lane_ram_pkg::ram_word_t     ram_rxd
);

    lane_ram_pkg::ram_addr_bus_t addr_pipe [lane_ram_pkg::RAM_LATENCY];

    // *****************************************************************
    // Address delay line, the data comes from the last stage
    // *****************************************************************

    always @(posedge clk) begin
        addr_pipe[0] <= ram_rxa;
        for (int s = 1; s < lane_ram_pkg::RAM_LATENCY; s++) begin
            addr_pipe[s] <= addr_pipe[s-1];
        end
    end

    // Each lane holds (lane * 37 + addr) mod 256
    always_comb begin
        lane_ram_pkg::lane_addr_t lane_addr;
        ram_rxd = '0;
        for (int i = 0; i < lane_ram_pkg::NUM_LANES; i++) begin
            lane_addr = addr_pipe[lane_ram_pkg::RAM_LATENCY - 1]
                        [(lane_ram_pkg::NUM_LANES - 1 - i) * lane_ram_pkg::ADDR_W
                         +: lane_ram_pkg::ADDR_W];
            ram_rxd[(lane_ram_pkg::NUM_LANES - 1 - i) * lane_ram_pkg::LANE_BYTE_W
                    +: lane_ram_pkg::LANE_BYTE_W] = lane_ram_pkg::lane_byte_t'(i * 37 + lane_addr);
        end
    end

endmodule

/* hw/ram2fifo.sv */
`timescale 1ns/1ps

module ram2fifo (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        fs,
    output logic                        fd,

    input  lane_ram_pkg::lane_addr_t    ram_rxa_init,

    input  frame_pkg::data_len_t        data_len,
    input  lane_ram_pkg::lane_mask_t    link,
    input  frame_pkg::frame_idx_t       data_idx,

    input  lane_ram_pkg::ram_word_t     ram_rxd,
    output lane_ram_pkg::ram_addr_bus_t ram_rxa,

    input  logic                        fifo_full,
    output frame_pkg::frame_byte_t      fifo_txd,
    output logic                        fifo_txen
);

    // *****************************************************************
    // Sequencer control shared by both datapaths
    // *****************************************************************

    frame_ctl_if ctl ();

    frame_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .fs        (fs),
        .fifo_full (fifo_full),
        .link      (link),
        .data_len  (data_len),
        .fd        (fd),
        .ctl       (ctl)
    );

    // *****************************************************************
    // RAM address side
    // *****************************************************************

    lane_addr_gen u_addr_gen (
        .clk          (clk),
        .rst          (rst),
        .ram_rxa_init (ram_rxa_init),
        .ram_rxa      (ram_rxa),
        .ctl          (ctl)
    );

    // *****************************************************************
    // FIFO write side
    // *****************************************************************

    frame_emitter u_emitter (
        .clk       (clk),
        .rst       (rst),
        .link      (link),
        .data_idx  (data_idx),
        .ram_rxd   (ram_rxd),
        .fifo_txd  (fifo_txd),
        .fifo_txen (fifo_txen),
        .ctl       (ctl)
    );

endmodule

/* hw/frame_emitter.sv */
`timescale 1ns/1ps

module frame_emitter (
    input  logic                     clk,
    input  logic                     rst,
    input  lane_ram_pkg::lane_mask_t link,
    input  frame_pkg::frame_idx_t    data_idx,
    input  lane_ram_pkg::ram_word_t  ram_rxd,
    output frame_pkg::frame_byte_t   fifo_txd,
    output logic                     fifo_txen,
    frame_ctl_if.emit                ctl
);

    lane_ram_pkg::lane_byte_t lane_byte;
    frame_pkg::frame_byte_t   byte_d;
    logic                     wr_d;
    frame_pkg::checksum_t     checksum;

    // Lane 0 is the top byte of the RAM word
    always_comb begin
        lane_byte = ram_rxd[(lane_ram_pkg::NUM_LANES - 1 - int'(ctl.lane))
                            * lane_ram_pkg::LANE_BYTE_W
                            +: lane_ram_pkg::LANE_BYTE_W];
    end

    // *****************************************************************
    // Byte selection for the current phase
    // *****************************************************************

    always_comb begin
        byte_d = lane_byte;
        wr_d   = 1'b1;
        case (ctl.phase)
            frame_pkg::SYNC_HI:  byte_d = frame_pkg::SYNC_HI_BYTE;
            frame_pkg::SYNC_LO:  byte_d = frame_pkg::SYNC_LO_BYTE;
            frame_pkg::MASK_PAD: byte_d = '0;
            frame_pkg::MASK:     byte_d = link;
            frame_pkg::IDX_HI:   byte_d = data_idx[15:8];
            frame_pkg::IDX_LO:   byte_d = data_idx[7:0];
            frame_pkg::SUM_HI:   byte_d = checksum[15:8];
            frame_pkg::SUM_LO:   byte_d = checksum[7:0];
            default: begin
                wr_d = ctl.take;  // Only lane data writes outside the fixed fields
            end
        endcase
    end

    always_ff @(posedge clk) begin
        fifo_txd <= byte_d;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fifo_txen <= 1'b0;
        end else begin
            fifo_txen <= wr_d;
        end
    end

    // *****************************************************************
    // Checksum over the lane data
    // *****************************************************************

    // Cleared in MASK and summed over every taken byte
    always_ff @(posedge clk) begin
        if (ctl.phase == frame_pkg::MASK) begin
            checksum <= '0;
        end else if (ctl.take) begin
            checksum <= checksum + frame_pkg::checksum_t'(lane_byte);
        end
    end

endmodule

/* hw/lane_addr_gen.sv */
`timescale 1ns/1ps

module lane_addr_gen (
    input  logic                        clk,
    input  logic                        rst,
    input  lane_ram_pkg::lane_addr_t    ram_rxa_init,
    output lane_ram_pkg::ram_addr_bus_t ram_rxa,
    frame_ctl_if.addr                   ctl
);

    lane_ram_pkg::lane_addr_t addr_q [lane_ram_pkg::NUM_LANES];
    logic                     load_all;

    assign load_all = ctl.addr_load && (ctl.phase == frame_pkg::INIT);

    // *****************************************************************
    // One address register per lane
    // *****************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < lane_ram_pkg::NUM_LANES; i++) begin
                addr_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < lane_ram_pkg::NUM_LANES; i++) begin
                if (load_all) begin
                    addr_q[i] <= ram_rxa_init;
                end else if (ctl.lane == lane_ram_pkg::lane_idx_t'(i)) begin
                    if (ctl.addr_load) begin
                        addr_q[i] <= ram_rxa_init;  // Each lane restarts at the base
                    end else if (ctl.addr_step) begin
                        addr_q[i] <= addr_q[i] + 1'b1;
                    end
                end
            end
        end
    end

    // Lane 0 goes to the top of the bus
    always_comb begin
        ram_rxa = '0;
        for (int i = 0; i < lane_ram_pkg::NUM_LANES; i++) begin
            ram_rxa[(lane_ram_pkg::NUM_LANES - 1 - i) * lane_ram_pkg::ADDR_W
                    +: lane_ram_pkg::ADDR_W] = addr_q[i];
        end
    end

    a_load_step_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(ctl.addr_load && ctl.addr_step)
    );

endmodule

/* hw/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fs,
    input  logic                     fifo_full,
    input  lane_ram_pkg::lane_mask_t link,
    input  frame_pkg::data_len_t     data_len,
    output logic                     fd,
    frame_ctl_if.seq                 ctl
);

    frame_pkg::frame_phase_e phase;
    frame_pkg::frame_phase_e phase_d;
    lane_ram_pkg::lane_idx_t lane;
    logic [$clog2(lane_ram_pkg::RAM_LATENCY + 1)-1:0] lat_cnt;
    frame_pkg::data_len_t    len_cnt;
    logic                    lat_last;
    logic                    len_last;
    logic                    last_lane;

    assign lat_last  = (lat_cnt == lane_ram_pkg::RAM_LATENCY - 1);
    assign len_last  = (len_cnt == data_len
                        - frame_pkg::data_len_t'(lane_ram_pkg::RAM_LATENCY + 1));
    assign last_lane = (lane == lane_ram_pkg::lane_idx_t'(lane_ram_pkg::NUM_LANES - 1));

    // *****************************************************************
    // Phase register and next phase
    // *****************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= frame_pkg::IDLE;
        end else begin
            phase <= phase_d;
        end
    end

    always_comb begin
        phase_d = phase;
        case (phase)
            frame_pkg::IDLE:     phase_d = frame_pkg::WAIT;
            frame_pkg::WAIT:     if (!fifo_full) phase_d = frame_pkg::READY;
            frame_pkg::READY:    if (fs) phase_d = frame_pkg::INIT;
            frame_pkg::INIT:     phase_d = frame_pkg::SYNC_HI;
            frame_pkg::SYNC_HI:  phase_d = frame_pkg::SYNC_LO;
            frame_pkg::SYNC_LO:  phase_d = frame_pkg::MASK_PAD;
            frame_pkg::MASK_PAD: phase_d = frame_pkg::MASK;
            frame_pkg::MASK:     phase_d = frame_pkg::IDX_HI;
            frame_pkg::IDX_HI:   phase_d = frame_pkg::IDX_LO;
            frame_pkg::IDX_LO:   phase_d = frame_pkg::LANE_CHECK;
            frame_pkg::LANE_CHECK: begin
                if (link[lane]) begin
                    phase_d = frame_pkg::LANE_PRIME;
                end else if (last_lane) begin
                    phase_d = frame_pkg::SUM_HI;
                end
            end
            frame_pkg::LANE_PRIME: if (lat_last) phase_d = frame_pkg::LANE_READ;
            frame_pkg::LANE_READ:  if (len_last) phase_d = frame_pkg::LANE_DRAIN;
            frame_pkg::LANE_DRAIN: begin
                if (lat_last) begin
                    phase_d = last_lane ? frame_pkg::SUM_HI : frame_pkg::LANE_CHECK;
                end
            end
            frame_pkg::SUM_HI:   phase_d = frame_pkg::SUM_LO;
            frame_pkg::SUM_LO:   phase_d = frame_pkg::DONE;
            frame_pkg::DONE:     if (!fs) phase_d = frame_pkg::WAIT;
            default:             phase_d = frame_pkg::IDLE;
        endcase
    end

    // *****************************************************************
    // Lane walk and cycle counters
    // *****************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lane <= '0;
        end else if (phase == frame_pkg::INIT) begin
            lane <= '0;
        end else if (!last_lane) begin
            if ((phase == frame_pkg::LANE_CHECK && !link[lane]) ||
                (phase == frame_pkg::LANE_DRAIN && lat_last)) begin
                lane <= lane + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lat_cnt <= '0;
        end else if ((phase == frame_pkg::LANE_PRIME || phase == frame_pkg::LANE_DRAIN)
                     && !lat_last) begin
            lat_cnt <= lat_cnt + 1'b1;
        end else begin
            lat_cnt <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            len_cnt <= '0;
        end else if (phase == frame_pkg::LANE_READ && !len_last) begin
            len_cnt <= len_cnt + 1'b1;
        end else begin
            len_cnt <= '0;
        end
    end

    // Rises one cycle into DONE so the last checksum byte is already out
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd <= 1'b0;
        end else begin
            fd <= (phase == frame_pkg::DONE) && fs;
        end
    end

    assign ctl.phase     = phase;
    assign ctl.lane      = lane;
    assign ctl.addr_load = (phase == frame_pkg::INIT) || (phase == frame_pkg::LANE_CHECK);
    assign ctl.addr_step = (phase == frame_pkg::LANE_PRIME) || (phase == frame_pkg::LANE_READ);
    assign ctl.take      = (phase == frame_pkg::LANE_READ) || (phase == frame_pkg::LANE_DRAIN);

    a_take_enabled_lane: assert property (
        @(posedge clk) disable iff (rst) ctl.take |-> link[ctl.lane]
    );

    // The lane number only steps up by one and never wraps past lane 7
    a_lane_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (ctl.lane != $past(ctl.lane)) |->
            ((int'(ctl.lane) == int'($past(ctl.lane)) + 1)
             || ($past(phase) == frame_pkg::INIT))
    );

endmodule

/* hw/frame_ctl_if.sv */
`timescale 1ns/1ps

interface frame_ctl_if;

    frame_pkg::frame_phase_e phase;
    lane_ram_pkg::lane_idx_t lane;
    logic                    addr_load;  // All lanes in INIT, current lane in LANE_CHECK
    logic                    addr_step;  // Current lane moves to its next byte
    logic                    take;       // A data byte of the current lane is on ram_rxd

    modport seq (
        output phase,
        output lane,
        output addr_load,
        output addr_step,
        output take
    );

    modport addr (
        input phase,
        input lane,
        input addr_load,
        input addr_step
    );

    modport emit (
        input phase,
        input lane,
        input take
    );

endinterface

/* hw/lane_ram_pkg.sv */
package lane_ram_pkg;

    localparam int NUM_LANES   = 8;
    localparam int RAM_LATENCY = 2;   // Cycles from address to data
    localparam int ADDR_W      = 12;
    localparam int LANE_BYTE_W = 8;

    typedef logic [ADDR_W-1:0]      lane_addr_t;
    typedef logic [LANE_BYTE_W-1:0] lane_byte_t;
    typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;

    // Bit i enables lane i
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // Lane 0 sits in the top byte of the read word
    typedef logic [NUM_LANES*LANE_BYTE_W-1:0] ram_word_t;

    // Lane 0 sits in the top twelve bits of the address bus
    typedef logic [NUM_LANES*ADDR_W-1:0] ram_addr_bus_t;

endpackage

/* hw/frame_pkg.sv */
package frame_pkg;

    localparam int DATA_LEN_W  = 12;
    localparam int FRAME_IDX_W = 16;
    localparam int CHECKSUM_W  = 16;
    localparam int BYTE_W      = 8;

    typedef logic [BYTE_W-1:0]      frame_byte_t;
    typedef logic [DATA_LEN_W-1:0]  data_len_t;   // Bytes per lane, at least 4
    typedef logic [FRAME_IDX_W-1:0] frame_idx_t;
    typedef logic [CHECKSUM_W-1:0]  checksum_t;   // Sum of data bytes modulo 2^16

    localparam frame_byte_t SYNC_HI_BYTE = 8'h55;
    localparam frame_byte_t SYNC_LO_BYTE = 8'hAA;

    typedef enum logic [4:0] {
        IDLE,
        WAIT,        // Waits for room in the FIFO
        READY,       // Waits for fs
        INIT,
        SYNC_HI,
        SYNC_LO,
        MASK_PAD,
        MASK,
        IDX_HI,
        IDX_LO,
        LANE_CHECK,
        LANE_PRIME,  // Addresses go out before any data returns
        LANE_READ,
        LANE_DRAIN,  // Last bytes still in flight from the RAM
        SUM_HI,
        SUM_LO,
        DONE
    } frame_phase_e;

endpackage
